// ==== hw/exec_config.svh ====
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// ======================================================================
// Execute stage widths
// ======================================================================

// ALU operands, results and data memory words
`define EX_WORD_WIDTH      16

// Program counter and program memory addressing
`define EX_PC_WIDTH        12
`define EX_PMEM_ADDR_WIDTH 12

// Data memory addressing
`define EX_DMEM_ADDR_WIDTH 12

// Register file index
`define EX_REG_IDX_WIDTH   4

// Added to pc for the link result
`define EX_PC_INCREMENT    2

`endif

// ==== hw/exec_pkg.sv ====
`include "exec_config.svh"

package exec_pkg;

    // ==================================================================
    // Plain vector types
    // ==================================================================
    typedef logic [`EX_WORD_WIDTH-1:0]      word_t;
    typedef logic [`EX_PC_WIDTH-1:0]        pc_t;
    typedef logic [`EX_PMEM_ADDR_WIDTH-1:0] pmem_addr_t;
    typedef logic [`EX_DMEM_ADDR_WIDTH-1:0] dmem_addr_t;
    typedef logic [`EX_REG_IDX_WIDTH-1:0]   reg_idx_t;

    // Cycle number inside a multi-cycle instruction
    typedef logic [2:0]                     instr_cycle_t;

    // ==================================================================
    // Encoded operations
    // ==================================================================
    typedef enum logic [3:0] {
        ALU_NONE      = 4'd0,
        ALU_ADD       = 4'd1,
        ALU_MUL       = 4'd2,
        ALU_SLL       = 4'd3,
        ALU_SRL       = 4'd4,
        ALU_SRA       = 4'd5,
        ALU_AND       = 4'd6,
        ALU_OR        = 4'd7,
        ALU_XOR       = 4'd8,
        ALU_PASS_SRC2 = 4'd9
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE = 2'd0,
        BR_EQ0  = 2'd1,
        BR_GT0  = 2'd2,
        BR_LT0  = 2'd3
    } branch_cond_e;

    // ==================================================================
    // Bundles
    // ==================================================================
    typedef struct packed {
        alu_op_e      alu_op;
        logic         neg_src2;
        branch_cond_e branch_cond;
        logic         jump;
        logic         load;
        logic         store;
        logic         write_res;
        logic         link;
    } ex_ctrl_t;

    // Instruction as issued by decode
    typedef struct packed {
        ex_ctrl_t     ctrl;
        word_t        src1;
        word_t        src2;
        word_t        src3;
        pc_t          pc;
        reg_idx_t     res_reg_idx;
        instr_cycle_t cycle;
        logic         bubble;
    } ex_issue_t;

    typedef struct packed {
        logic       flush_if;
        logic       flush_dc_ex;
        logic       set_pc;
        pmem_addr_t branch_pc;
    } redirect_t;

    typedef struct packed {
        logic       load;
        logic       store;
        dmem_addr_t rd_addr;
        dmem_addr_t wr_addr;
        word_t      wr_word;
    } dmem_req_t;

    typedef struct packed {
        logic     write;
        reg_idx_t reg_idx;
        word_t    res;
    } writeback_t;

endpackage

// ==== hw/ex_issue_reg.sv ====
`timescale 1ns/100ps

module ex_issue_reg (
    input  logic                clock,
    input  logic                reset,
    input  exec_pkg::ex_issue_t issue,
    input  logic                flush,
    output exec_pkg::ex_issue_t issue_q,
    output logic                killed,
    output logic                bubble
);

    // Sampled instruction and flush request
    exec_pkg::ex_issue_t issue_r;
    logic                flush_r;

    // ==================================================================
    // Input register
    // ==================================================================
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            issue_r <= '0;
            flush_r <= 1'b0;
        end else begin
            issue_r <= issue;
            flush_r <= flush;
        end
    end

    // ==================================================================
    // Flush masking
    // ==================================================================
    // A flushed instruction keeps its operands but loses every field
    // that could act on the pipeline, memory or register file
    always_comb begin
        issue_q = issue_r;
        if (flush_r) begin
            issue_q.ctrl        = exec_pkg::ex_ctrl_t'('0);
            issue_q.pc          = '0;
            issue_q.res_reg_idx = '0;
            issue_q.cycle       = '0;
        end
        issue_q.bubble = issue_r.bubble | flush_r;
    end

    assign killed = flush_r;

    // Bubble from decode or from our own flush
    assign bubble = issue_q.bubble;

    // ==================================================================
    // Checks
    // ==================================================================
    // Decode never issues a load and a store in the same instruction,
    // so the data memory sees at most one request per cycle
    a_no_load_and_store: assert property (
        @(posedge clock) disable iff (reset)
        !(issue_q.ctrl.load && issue_q.ctrl.store)
    ) else $error("ex_issue_reg: load and store issued together");

endmodule

// ==== hw/int_alu.sv ====
`timescale 1ns/100ps

module int_alu (
    input  logic                clock,
    input  logic                reset,
    input  exec_pkg::ex_issue_t issue_q,
    input  logic                killed,
    output exec_pkg::word_t     alu_res,
    output exec_pkg::word_t     alu_res_prev
);

    // Second operand after optional negation
    exec_pkg::word_t src2_mod;

    // ==================================================================
    // Operand preparation
    // ==================================================================
    // Subtraction is an add with src2 negated in two's complement
    always_comb begin
        if (issue_q.ctrl.neg_src2) begin
            src2_mod = ~issue_q.src2 + 1'b1;
        end else begin
            src2_mod = issue_q.src2;
        end
    end

    // ==================================================================
    // Operation select
    // ==================================================================
    always_comb begin
        if (killed) begin
            alu_res = '0;
        end else begin
            case (issue_q.ctrl.alu_op)
                exec_pkg::ALU_ADD: begin
                    alu_res = issue_q.src1 + src2_mod;
                end
                exec_pkg::ALU_MUL: begin
                    // Low word of the product only
                    alu_res = issue_q.src1 * src2_mod;
                end
                exec_pkg::ALU_SLL: begin
                    alu_res = issue_q.src1 << src2_mod;
                end
                exec_pkg::ALU_SRL: begin
                    alu_res = issue_q.src1 >> src2_mod;
                end
                exec_pkg::ALU_SRA: begin
                    // Sign bit of src1 fills from the left
                    alu_res = exec_pkg::word_t'($signed(issue_q.src1) >>> src2_mod);
                end
                exec_pkg::ALU_AND: begin
                    alu_res = issue_q.src1 & src2_mod;
                end
                exec_pkg::ALU_OR: begin
                    alu_res = issue_q.src1 | src2_mod;
                end
                exec_pkg::ALU_XOR: begin
                    alu_res = issue_q.src1 ^ src2_mod;
                end
                exec_pkg::ALU_PASS_SRC2: begin
                    alu_res = src2_mod;
                end
                default: begin
                    alu_res = '0;
                end
            endcase
        end
    end

    // ==================================================================
    // Previous result
    // ==================================================================
    // Second phase of a conditional branch tests the result of phase 0
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            alu_res_prev <= '0;
        end else begin
            alu_res_prev <= alu_res;
        end
    end

endmodule

// ==== hw/branch_unit.sv ====
`timescale 1ns/100ps
`include "exec_config.svh"

module branch_unit (
    input  exec_pkg::ex_issue_t issue_q,
    input  logic                killed,
    input  exec_pkg::word_t     alu_res,
    input  exec_pkg::word_t     alu_res_prev,
    output exec_pkg::redirect_t redirect
);

    // Condition hits for the two branch phases
    logic phase0_hit;
    logic phase1_hit;

    // ==================================================================
    // Condition evaluation
    // ==================================================================
    function automatic logic cond_holds(
        input exec_pkg::branch_cond_e cond,
        input exec_pkg::word_t        value
    );
        logic sign;
        logic is_zero;
        sign    = value[`EX_WORD_WIDTH-1];
        is_zero = (value == '0);
        case (cond)
            exec_pkg::BR_EQ0: cond_holds = is_zero;
            exec_pkg::BR_GT0: cond_holds = !sign && !is_zero;
            exec_pkg::BR_LT0: cond_holds = sign;
            default:          cond_holds = 1'b0;
        endcase
    endfunction

    // Phase 0 looks at this cycle's result
    assign phase0_hit = (issue_q.cycle == 3'd0)
                      && cond_holds(issue_q.ctrl.branch_cond, alu_res);

    // Phase 1 looks at the result of phase 0, one cycle back
    assign phase1_hit = (issue_q.cycle == 3'd1)
                      && cond_holds(issue_q.ctrl.branch_cond, alu_res_prev);

    // ==================================================================
    // Redirect request
    // ==================================================================
    always_comb begin
        redirect = '0;
        if (!killed) begin
            if (issue_q.ctrl.jump) begin
                redirect.flush_if    = 1'b1;
                redirect.flush_dc_ex = 1'b1;
                redirect.set_pc      = 1'b1;
                redirect.branch_pc   = alu_res[`EX_PMEM_ADDR_WIDTH-1:0];
            end else if (phase0_hit) begin
                // Stop fetching but keep DC and EX, the target is
                // computed by the next instruction word
                redirect.flush_if    = 1'b1;
            end else if (phase1_hit) begin
                redirect.flush_if    = 1'b1;
                redirect.flush_dc_ex = 1'b1;
                redirect.set_pc      = 1'b1;
                redirect.branch_pc   = alu_res[`EX_PMEM_ADDR_WIDTH-1:0];
            end
        end
    end

    // ==================================================================
    // Checks
    // ==================================================================
    // Fetch must always be stopped when the pc is redirected
    a_set_pc_flushes: assert final (
        !redirect.set_pc || (redirect.flush_if && redirect.flush_dc_ex)
    ) else $error("branch_unit: set_pc without full flush");

endmodule

// ==== hw/ex_result_router.sv ====
`timescale 1ns/100ps
`include "exec_config.svh"

module ex_result_router (
    input  exec_pkg::ex_issue_t  issue_q,
    input  exec_pkg::word_t      alu_res,
    output exec_pkg::dmem_req_t  dmem,
    output exec_pkg::writeback_t writeback
);

    // Return address for link instructions
    exec_pkg::pc_t link_pc;

    assign link_pc = issue_q.pc + exec_pkg::pc_t'(`EX_PC_INCREMENT);

    // ==================================================================
    // Data memory request
    // ==================================================================
    // Addresses come from the ALU, idle fields stay at zero
    always_comb begin
        dmem       = '0;
        dmem.load  = issue_q.ctrl.load;
        dmem.store = issue_q.ctrl.store;
        if (issue_q.ctrl.load) begin
            dmem.rd_addr = alu_res[`EX_DMEM_ADDR_WIDTH-1:0];
        end
        if (issue_q.ctrl.store) begin
            dmem.wr_addr = alu_res[`EX_DMEM_ADDR_WIDTH-1:0];
            dmem.wr_word = issue_q.src3;
        end
    end

    // ==================================================================
    // Writeback result
    // ==================================================================
    always_comb begin
        writeback.write   = issue_q.ctrl.write_res;
        writeback.reg_idx = issue_q.res_reg_idx;
        if (issue_q.ctrl.link) begin
            // Zero-extend the return pc to a full word
            writeback.res = {{(`EX_WORD_WIDTH-`EX_PC_WIDTH){1'b0}}, link_pc};
        end else begin
            writeback.res = alu_res;
        end
    end

endmodule

// ==== hw/exec_stage.sv ====
`timescale 1ns/100ps

module exec_stage (
    input  logic                 clock,
    input  logic                 reset,
    input  exec_pkg::ex_issue_t  issue,
    input  logic                 flush,
    output logic                 bubble,
    output exec_pkg::redirect_t  redirect,
    output exec_pkg::dmem_req_t  dmem,
    output exec_pkg::writeback_t writeback
);

    // Sampled instruction with flush already applied
    exec_pkg::ex_issue_t issue_q;
    logic                killed;

    // Current and previous ALU result
    exec_pkg::word_t     alu_res;
    exec_pkg::word_t     alu_res_prev;

    ex_issue_reg u_issue_reg (
        .clock   (clock),
        .reset   (reset),
        .issue   (issue),
        .flush   (flush),
        .issue_q (issue_q),
        .killed  (killed),
        .bubble  (bubble)
    );

    int_alu u_alu (
        .clock        (clock),
        .reset        (reset),
        .issue_q      (issue_q),
        .killed       (killed),
        .alu_res      (alu_res),
        .alu_res_prev (alu_res_prev)
    );

    branch_unit u_branch (
        .issue_q      (issue_q),
        .killed       (killed),
        .alu_res      (alu_res),
        .alu_res_prev (alu_res_prev),
        .redirect     (redirect)
    );

    ex_result_router u_router (
        .issue_q   (issue_q),
        .alu_res   (alu_res),
        .dmem      (dmem),
        .writeback (writeback)
    );

endmodule

// ==== sim/exec_tb_model.svh ====
`ifndef EXEC_TB_MODEL_SVH
`define EXEC_TB_MODEL_SVH

`include "exec_config.svh"

// ======================================================================
// Reference model of the execute stage
// ======================================================================

function automatic exec_pkg::word_t model_alu(input exec_pkg::ex_issue_t iss);
    exec_pkg::word_t a;
    exec_pkg::word_t b;
    exec_pkg::word_t r;
    logic [2*`EX_WORD_WIDTH-1:0] product;
    a = iss.src1;
    b = iss.ctrl.neg_src2 ? exec_pkg::word_t'(0 - iss.src2) : iss.src2;
    r = '0;
    case (iss.ctrl.alu_op)
        exec_pkg::ALU_ADD: r = a + b;
        exec_pkg::ALU_MUL: begin
            product = a * b;
            r = product[`EX_WORD_WIDTH-1:0];
        end
        exec_pkg::ALU_SLL: r = (b >= `EX_WORD_WIDTH) ? '0 : a << b;
        exec_pkg::ALU_SRL: r = (b >= `EX_WORD_WIDTH) ? '0 : a >> b;
        exec_pkg::ALU_SRA: begin
            // One bit at a time, copying the sign in from the left
            r = a;
            for (int i = 0; i < `EX_WORD_WIDTH && i < b; i++) begin
                r = {r[`EX_WORD_WIDTH-1], r[`EX_WORD_WIDTH-1:1]};
            end
        end
        exec_pkg::ALU_AND: r = a & b;
        exec_pkg::ALU_OR: r = a | b;
        exec_pkg::ALU_XOR: r = a ^ b;
        exec_pkg::ALU_PASS_SRC2: r = b;
        default: r = '0;
    endcase
    return r;
endfunction

function automatic logic cond_met(input exec_pkg::branch_cond_e cond,
                                  input exec_pkg::word_t v);
    case (cond)
        exec_pkg::BR_EQ0: return v == '0;
        exec_pkg::BR_GT0: return !v[`EX_WORD_WIDTH-1] && (v != '0);
        exec_pkg::BR_LT0: return v[`EX_WORD_WIDTH-1];
        default: return 1'b0;
    endcase
endfunction

function automatic exec_pkg::redirect_t model_redirect(input exec_pkg::ex_issue_t iss,
                                                       input exec_pkg::word_t alu,
                                                       input exec_pkg::word_t prev);
    exec_pkg::redirect_t r;
    r = '0;
    if (iss.ctrl.jump || (iss.cycle == 3'd1 && cond_met(iss.ctrl.branch_cond, prev))) begin
        r.flush_if    = 1'b1;
        r.flush_dc_ex = 1'b1;
        r.set_pc      = 1'b1;
        r.branch_pc   = alu[`EX_PMEM_ADDR_WIDTH-1:0];
    end else if (iss.cycle == 3'd0 && cond_met(iss.ctrl.branch_cond, alu)) begin
        r.flush_if = 1'b1;
    end
    return r;
endfunction

function automatic exec_pkg::dmem_req_t model_dmem(input exec_pkg::ex_issue_t iss,
                                                   input exec_pkg::word_t alu);
    exec_pkg::dmem_req_t d;
    d       = '0;
    d.load  = iss.ctrl.load;
    d.store = iss.ctrl.store;
    if (iss.ctrl.load) d.rd_addr = alu[`EX_DMEM_ADDR_WIDTH-1:0];
    if (iss.ctrl.store) begin
        d.wr_addr = alu[`EX_DMEM_ADDR_WIDTH-1:0];
        d.wr_word = iss.src3;
    end
    return d;
endfunction

function automatic exec_pkg::writeback_t model_wb(input exec_pkg::ex_issue_t iss,
                                                 input exec_pkg::word_t alu);
    exec_pkg::writeback_t w;
    w.write   = iss.ctrl.write_res;
    w.reg_idx = iss.res_reg_idx;
    // Return address wraps inside the pc width, then zero-extends
    w.res = iss.ctrl.link ? exec_pkg::word_t'(exec_pkg::pc_t'(iss.pc + `EX_PC_INCREMENT)) : alu;
    return w;
endfunction

`endif

// ==== sim/exec_tb.sv ====
`timescale 1ns/100ps

module exec_tb;

    localparam int DRAIN_LIMIT = 20;
    localparam int T_RESET = 0;
    localparam int T_ALU = 1;
    localparam int T_LINK = 2;
    localparam int T_LDST = 3;
    localparam int T_JUMP = 4;
    localparam int T_BRANCH = 5;
    localparam int T_FLUSH = 6;

    string test_names [0:6] = '{"reset", "alu_ops", "link", "load_store",
                                "jump", "branch", "flush"};

    logic                 clock;
    logic                 reset;
    exec_pkg::ex_issue_t  issue;
    logic                 flush;
    logic                 bubble;
    exec_pkg::redirect_t  redirect;
    exec_pkg::dmem_req_t  dmem;
    exec_pkg::writeback_t writeback;

    // Expected outputs for the instruction sampled at the last edge
    logic                 exp_bubble;
    exec_pkg::redirect_t  exp_redirect;
    exec_pkg::dmem_req_t  exp_dmem;
    exec_pkg::writeback_t exp_wb;
    exec_pkg::word_t      exp_alu;

    int errors;
    int cur_test;
    int chk_test;
    int drive_seq;
    int exp_seq;
    int checked_seq;

    `include "exec_tb_model.svh"

    exec_stage UUT (
        .clock     (clock),
        .reset     (reset),
        .issue     (issue),
        .flush     (flush),
        .bubble    (bubble),
        .redirect  (redirect),
        .dmem      (dmem),
        .writeback (writeback)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // ==================================================================
    // Model update, one step per sampled issue
    // ==================================================================
    always @(posedge clock or posedge reset) begin : model_update
        exec_pkg::word_t alu_now;
        if (reset) begin
            exp_bubble   <= 1'b0;
            exp_redirect <= '0;
            exp_dmem     <= '0;
            exp_wb       <= '0;
            exp_alu      <= '0;
            chk_test     <= T_RESET;
            exp_seq      <= 0;
            checked_seq  <= 0;
        end else begin
            if (flush) begin
                alu_now      = '0;
                exp_redirect <= '0;
                exp_dmem     <= '0;
                exp_wb       <= '0;
            end else begin
                alu_now      = model_alu(issue);
                exp_redirect <= model_redirect(issue, alu_now, exp_alu);
                exp_dmem     <= model_dmem(issue, alu_now);
                exp_wb       <= model_wb(issue, alu_now);
            end
            exp_alu     <= alu_now;
            exp_bubble  <= issue.bubble | flush;
            chk_test    <= cur_test;
            exp_seq     <= drive_seq;
            checked_seq <= exp_seq;
        end
    end

    // ==================================================================
    // Checks
    // ==================================================================
    task automatic report_mismatch(input int test, input string what,
                                   input logic [63:0] expected, input logic [63:0] actual);
        errors++;
        $display("ERR %s %s at %0t: expected %h, actual %h",
                 test_names[test], what, $time, expected, actual);
    endtask

    a_writeback: assert property (@(posedge clock) disable iff (reset) writeback == exp_wb)
        else report_mismatch($sampled(chk_test), "writeback", $sampled(exp_wb),
                             $sampled(writeback));

    a_dmem: assert property (@(posedge clock) disable iff (reset) dmem == exp_dmem)
        else report_mismatch($sampled(chk_test), "dmem", $sampled(exp_dmem), $sampled(dmem));

    a_redirect: assert property (@(posedge clock) disable iff (reset) redirect == exp_redirect)
        else report_mismatch($sampled(chk_test), "redirect", $sampled(exp_redirect),
                             $sampled(redirect));

    a_bubble: assert property (@(posedge clock) disable iff (reset) bubble == exp_bubble)
        else report_mismatch($sampled(chk_test), "bubble", $sampled(exp_bubble),
                             $sampled(bubble));

    // ==================================================================
    // Stimulus helpers
    // ==================================================================
    task automatic drive(input exec_pkg::ex_issue_t iss, input logic fl, input int test);
        @(posedge clock);
        #10;
        issue     = iss;
        flush     = fl;
        cur_test  = test;
        drive_seq = drive_seq + 1;
    endtask

    // Idle issue, then wait until every driven issue has been compared
    task automatic drain(input int test);
        int waited;
        waited = 0;
        drive('0, 1'b0, test);
        while (checked_seq != drive_seq && waited < DRAIN_LIMIT) begin
            @(posedge clock);
            #1;
            waited++;
        end
        if (checked_seq != drive_seq) begin
            $display("Timeout: outputs of the %s phase were not all checked", test_names[test]);
            $display("Errors: %0d", errors);
            $display("Simulation FAILED");
            $finish;
        end
    endtask

    function automatic exec_pkg::ex_issue_t rand_issue(input exec_pkg::alu_op_e op,
                                                       input logic neg);
        exec_pkg::ex_issue_t iss;
        int amount;
        iss                = '0;
        iss.ctrl.alu_op    = op;
        iss.ctrl.neg_src2  = neg;
        iss.ctrl.write_res = 1'b1;
        iss.src1           = $urandom;
        iss.src2           = $urandom;
        iss.src3           = $urandom;
        iss.pc             = $urandom;
        iss.res_reg_idx    = $urandom;
        // Keep most shift amounts inside the word after negation
        if (op inside {exec_pkg::ALU_SLL, exec_pkg::ALU_SRL, exec_pkg::ALU_SRA}) begin
            amount   = $urandom_range(0, 19);
            iss.src2 = neg ? exec_pkg::word_t'(0 - amount) : exec_pkg::word_t'(amount);
        end
        return iss;
    endfunction

    // ==================================================================
    // Test sequence
    // ==================================================================
    initial begin
        exec_pkg::ex_issue_t iss;
        exec_pkg::word_t     vals [0:4];
        errors    = 0;
        cur_test  = T_RESET;
        drive_seq = 0;
        issue     = '0;
        flush     = 1'b0;
        reset     = 1'b1;
        void'($urandom(32'h0e307181));
        vals = '{16'h0000, 16'h0123, 16'h8001, 16'hffff, 16'h0000};
        vals[4] = $urandom;
        repeat (2) @(posedge clock);
        #10;
        reset = 1'b0;

        for (int op = 0; op < 10; op++) begin
            for (int neg = 0; neg < 2; neg++) begin
                repeat (4) drive(rand_issue(exec_pkg::alu_op_e'(op), neg[0]), 1'b0, T_ALU);
            end
        end
        drain(T_ALU);

        repeat (6) begin
            iss           = rand_issue(exec_pkg::ALU_ADD, 1'b0);
            iss.ctrl.link = 1'b1;
            drive(iss, 1'b0, T_LINK);
        end
        iss.pc = 12'hfff;
        drive(iss, 1'b0, T_LINK);
        drain(T_LINK);

        repeat (4) begin
            iss           = rand_issue(exec_pkg::ALU_ADD, $urandom);
            iss.ctrl.load = 1'b1;
            drive(iss, 1'b0, T_LDST);
            iss            = rand_issue(exec_pkg::ALU_ADD, $urandom);
            iss.ctrl.store = 1'b1;
            drive(iss, 1'b0, T_LDST);
            drive(rand_issue(exec_pkg::ALU_XOR, 1'b0), 1'b0, T_LDST);
        end
        drain(T_LDST);

        repeat (4) begin
            iss           = rand_issue(exec_pkg::ALU_ADD, $urandom);
            iss.ctrl.jump = 1'b1;
            drive(iss, 1'b0, T_JUMP);
        end
        drain(T_JUMP);

        // Phase 0 puts the tested value on the ALU, phase 1 adds the target
        for (int c = 0; c < 4; c++) begin
            for (int v = 0; v < 5; v++) begin
                iss                  = rand_issue(exec_pkg::ALU_PASS_SRC2, 1'b0);
                iss.src2             = vals[v];
                iss.ctrl.branch_cond = exec_pkg::branch_cond_e'(c);
                drive(iss, 1'b0, T_BRANCH);
                iss                  = rand_issue(exec_pkg::ALU_ADD, 1'b0);
                iss.ctrl.branch_cond = exec_pkg::branch_cond_e'(c);
                iss.cycle            = 3'd1;
                drive(iss, 1'b0, T_BRANCH);
            end
        end
        drain(T_BRANCH);

        repeat (10) begin
            iss                  = rand_issue(exec_pkg::alu_op_e'($urandom_range(0, 9)), $urandom);
            iss.ctrl.branch_cond = exec_pkg::branch_cond_e'($urandom_range(0, 3));
            iss.ctrl.jump        = $urandom;
            iss.ctrl.load        = $urandom;
            iss.ctrl.store       = !iss.ctrl.load && $urandom_range(0, 1);
            iss.ctrl.link        = $urandom;
            iss.cycle            = $urandom_range(0, 1);
            iss.bubble           = $urandom_range(0, 1);
            drive(iss, $urandom_range(0, 1), T_FLUSH);
        end
        drain(T_FLUSH);

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+hw
+incdir+sim
hw/exec_pkg.sv
hw/ex_issue_reg.sv
hw/int_alu.sv
hw/branch_unit.sv
hw/ex_result_router.sv
hw/exec_stage.sv
sim/exec_tb.sv
